//--- verilog/mips_debug_pkg.sv
`default_nettype none

package mips_debug_pkg;

    localparam int NB_DATA        = 32;
    localparam int NB_BYTE        = 8;
    localparam int NB_REG         = 5;
    localparam int NB_IADDR       = 6;                       // 64 instruction words
    localparam int NB_OP          = 6;
    localparam int NB_IMM         = 16;
    localparam int BYTES_PER_WORD = NB_DATA / NB_BYTE;
    localparam int NB_BYTE_IDX    = $clog2(BYTES_PER_WORD);

    localparam int OVERSAMPLING   = 16;                      // ticks per bit
    localparam int CLKS_PER_TICK  = 2;                       // 32 clocks per bit
    localparam int NB_OS_CNT      = $clog2(OVERSAMPLING);
    localparam int NB_BIT_CNT     = $clog2(NB_BYTE);
    localparam int NB_DIV_CNT     = $clog2(CLKS_PER_TICK);

    localparam logic [NB_DATA-1:0] HALT_WORD = '1;

    localparam logic [NB_BYTE-1:0] CMD_LOAD = 8'h4C;         // 'L'
    localparam logic [NB_BYTE-1:0] CMD_RUN  = 8'h43;         // 'C'
    localparam logic [NB_BYTE-1:0] CMD_STEP = 8'h53;         // 'S'

    typedef logic [NB_DATA-1:0]  word_t;
    typedef logic [NB_BYTE-1:0]  byte_t;
    typedef logic [NB_REG-1:0]   reg_idx_t;
    typedef logic [NB_IADDR-1:0] iaddr_t;
    typedef logic [NB_OP-1:0]    op_t;

    // opcode field, bits 31:26
    localparam op_t OP_RTYPE = 6'b000000;
    localparam op_t OP_BEQ   = 6'b000100;
    localparam op_t OP_ADDIU = 6'b001001;
    localparam op_t OP_ORI   = 6'b001101;
    localparam op_t OP_LUI   = 6'b001111;

    // funct field of R-type, bits 5:0
    localparam op_t FN_ADDU  = 6'b100001;
    localparam op_t FN_SUBU  = 6'b100011;
    localparam op_t FN_AND   = 6'b100100;
    localparam op_t FN_OR    = 6'b100101;
    localparam op_t FN_SLT   = 6'b101010;

endpackage

`default_nettype wire

//--- verilog/mips_debug_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface serial_if import mips_debug_pkg::*; ();
    byte_t rx_data;       // valid with rx_done
    logic  rx_done;       // one-cycle pulse
    byte_t tx_data;
    logic  tx_start;      // only while tx idle
    logic  tx_done;       // end of stop bit

    modport uart_side (output rx_data, rx_done, tx_done, input tx_data, tx_start);
    modport dbg_side  (input rx_data, rx_done, tx_done, output tx_data, tx_start);
endinterface

interface core_dbg_if import mips_debug_pkg::*; ();
    logic     core_rst;   // clears pc and registers
    logic     imem_we;
    iaddr_t   imem_addr;
    word_t    imem_data;
    logic     run;        // level, core steps while high
    logic     prog_end;   // HALT sits at pc
    reg_idx_t dump_addr;
    word_t    dump_data;  // combinational read

    modport dbg_side (
        output core_rst, imem_we, imem_addr, imem_data, run, dump_addr,
        input  prog_end, dump_data
    );
    modport core_side (
        input  core_rst, imem_we, imem_addr, imem_data, run, dump_addr,
        output prog_end, dump_data
    );
endinterface

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import mips_debug_pkg::*; (
    input  wire   i_clk,
    input  wire   i_rst,
    input  wire   i_tick,
    input  wire   i_rx,
    output byte_t o_data,
    output logic  o_done
);
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t             state;
    logic [1:0]            rx_sync;   // metastability guard
    logic [NB_OS_CNT-1:0]  tick_cnt;
    logic [NB_BIT_CNT-1:0] bit_cnt;
    byte_t                 shift;

    assign o_data = shift;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_sync <= '1;                                    // line idles high
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    always_ff @(posedge i_clk) begin
        o_done <= 1'b0;
        if (i_rst) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (!rx_sync[1]) begin                    // start edge
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == NB_OS_CNT'(OVERSAMPLING / 2 - 1)) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_sync[1] ? RX_IDLE : RX_DATA;  // drop glitches
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_tick) begin
                        if (tick_cnt == NB_OS_CNT'(OVERSAMPLING - 1)) begin
                            tick_cnt <= '0;
                            shift    <= {rx_sync[1], shift[NB_BYTE-1:1]};  // lsb first
                            if (bit_cnt == NB_BIT_CNT'(NB_BYTE - 1)) begin
                                state <= RX_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (i_tick) begin
                        if (tick_cnt == NB_OS_CNT'(OVERSAMPLING - 1)) begin
                            o_done <= 1'b1;                   // middle of stop bit
                            state  <= RX_IDLE;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    a_done_single: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done |=> !o_done);

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import mips_debug_pkg::*; (
    input  wire   i_clk,
    input  wire   i_rst,
    input  wire   i_tick,
    input  wire   i_start,
    input  byte_t i_data,
    output logic  o_tx,
    output logic  o_done
);
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t             state;
    logic [NB_OS_CNT-1:0]  tick_cnt;
    logic [NB_BIT_CNT-1:0] bit_cnt;
    byte_t                 shift;
    logic                  bit_end;

    assign bit_end = i_tick && (tick_cnt == NB_OS_CNT'(OVERSAMPLING - 1));

    always_ff @(posedge i_clk) begin
        o_done <= 1'b0;
        if (i_rst) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_tx     <= 1'b1;
        end else begin
            if (i_tick && state != TX_IDLE) begin
                tick_cnt <= tick_cnt + 1'b1;                  // wraps every bit
            end
            case (state)
                TX_IDLE: begin
                    o_tx <= 1'b1;
                    if (i_start) begin
                        shift    <= i_data;
                        tick_cnt <= '0;
                        o_tx     <= 1'b0;                     // start bit
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        o_tx    <= shift[0];
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        shift <= shift >> 1;
                        if (bit_cnt == NB_BIT_CNT'(NB_BYTE - 1)) begin
                            o_tx  <= 1'b1;                    // stop bit
                            state <= TX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            o_tx    <= shift[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        o_done <= 1'b1;
                        state  <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    a_start_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_start |-> state == TX_IDLE);

endmodule

`default_nettype wire

//--- verilog/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart import mips_debug_pkg::*; (
    input  wire          i_clk,
    input  wire          i_rst,
    input  wire          i_rx,
    output logic         o_tx,
    serial_if.uart_side  sif
);
    logic [NB_DIV_CNT-1:0] div_cnt;
    logic                  tick;     // oversampling strobe

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == NB_DIV_CNT'(CLKS_PER_TICK - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    uart_rx uart_rx_inst (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_tick (tick),
        .i_rx   (i_rx),
        .o_data (sif.rx_data),
        .o_done (sif.rx_done)
    );

    uart_tx uart_tx_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_tick  (tick),
        .i_start (sif.tx_start),
        .i_data  (sif.tx_data),
        .o_tx    (o_tx),
        .o_done  (sif.tx_done)
    );

endmodule

`default_nettype wire

//--- verilog/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit import mips_debug_pkg::*; (
    input  wire           i_clk,
    input  wire           i_rst,
    serial_if.dbg_side    sif,
    core_dbg_if.dbg_side  dbg
);
    typedef enum logic [2:0] {ST_IDLE, ST_LOAD, ST_RUN, ST_STEP, ST_DUMP} dbg_state_t;

    dbg_state_t             state;
    logic [NB_BYTE_IDX-1:0] byte_cnt;   // byte within word, load and dump
    iaddr_t                 load_addr;
    reg_idx_t               dump_idx;
    word_t                  word_buf;
    word_t                  next_word;
    logic                   tx_busy;    // waiting for tx_done

    assign next_word     = {word_buf[NB_DATA-NB_BYTE-1:0], sif.rx_data};  // msb first
    assign dbg.run       = (state == ST_RUN) || (state == ST_STEP);
    assign dbg.dump_addr = dump_idx;

    always_ff @(posedge i_clk) begin
        sif.tx_start <= 1'b0;
        dbg.imem_we  <= 1'b0;
        dbg.core_rst <= 1'b0;
        if (i_rst) begin
            state     <= ST_IDLE;
            byte_cnt  <= '0;
            load_addr <= '0;
            dump_idx  <= '0;
            tx_busy   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (sif.rx_done) begin
                        case (sif.rx_data)
                            CMD_LOAD: begin
                                dbg.core_rst <= 1'b1;         // fresh registers and pc
                                byte_cnt     <= '0;
                                load_addr    <= '0;
                                state        <= ST_LOAD;
                            end
                            CMD_RUN:  state <= ST_RUN;
                            CMD_STEP: state <= ST_STEP;
                            default:  state <= ST_IDLE;       // unknown byte
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (dbg.imem_we && dbg.imem_data == HALT_WORD) begin
                        state <= ST_IDLE;                     // program complete
                    end else if (sif.rx_done) begin
                        word_buf <= next_word;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == NB_BYTE_IDX'(BYTES_PER_WORD - 1)) begin
                            dbg.imem_we   <= 1'b1;
                            dbg.imem_addr <= load_addr;
                            dbg.imem_data <= next_word;
                            load_addr     <= load_addr + 1'b1;
                        end
                    end
                end
                ST_RUN: begin
                    if (dbg.prog_end) begin
                        dump_idx <= '0;
                        byte_cnt <= '0;
                        state    <= ST_DUMP;
                    end
                end
                ST_STEP: begin                                // run high one cycle
                    dump_idx <= '0;
                    byte_cnt <= '0;
                    state    <= ST_DUMP;
                end
                ST_DUMP: begin
                    if (!tx_busy) begin
                        sif.tx_start <= 1'b1;
                        sif.tx_data  <= dbg.dump_data[(BYTES_PER_WORD - 1 - byte_cnt) * NB_BYTE
                                                      +: NB_BYTE];
                        tx_busy      <= 1'b1;
                    end else if (sif.tx_done) begin
                        tx_busy  <= 1'b0;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == NB_BYTE_IDX'(BYTES_PER_WORD - 1)) begin
                            dump_idx <= dump_idx + 1'b1;
                            if (dump_idx == '1) begin
                                state <= ST_IDLE;             // all 32 registers sent
                            end
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_we_in_load: assert property (@(posedge i_clk) disable iff (i_rst)
        dbg.imem_we |-> state == ST_LOAD);

endmodule

`default_nettype wire

//--- verilog/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_debug_pkg::*; (
    input  wire            i_clk,
    input  wire            i_rst,
    core_dbg_if.core_side  dbg
);
    iaddr_t   pc;
    iaddr_t   pc_next;
    word_t    imem [2**NB_IADDR];
    word_t    regs [2**NB_REG];
    word_t    instr;
    op_t      opcode;
    op_t      funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    logic [NB_IMM-1:0] imm;
    word_t    rs_val;
    word_t    rt_val;
    word_t    result;
    reg_idx_t wr_idx;
    logic     wr_en;
    logic     branch;
    logic     step;

    assign instr  = imem[pc];
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign imm    = instr[NB_IMM-1:0];
    assign rs_val = regs[rs];
    assign rt_val = regs[rt];

    assign dbg.prog_end  = (instr == HALT_WORD);
    assign dbg.dump_data = regs[dbg.dump_addr];
    assign step          = dbg.run && !dbg.prog_end;    // one instruction per clock

    always_comb begin
        result = '0;
        wr_en  = 1'b0;
        wr_idx = rt;                                        // I-type target
        branch = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                wr_en  = 1'b1;
                wr_idx = rd;
                case (funct)
                    FN_ADDU: result = rs_val + rt_val;
                    FN_SUBU: result = rs_val - rt_val;
                    FN_AND:  result = rs_val & rt_val;
                    FN_OR:   result = rs_val | rt_val;
                    FN_SLT:  result = ($signed(rs_val) < $signed(rt_val)) ? word_t'(1) : '0;
                    default: wr_en  = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                wr_en  = 1'b1;
                result = rs_val + {{(NB_DATA-NB_IMM){imm[NB_IMM-1]}}, imm};
            end
            OP_ORI: begin
                wr_en  = 1'b1;
                result = rs_val | {{(NB_DATA-NB_IMM){1'b0}}, imm};
            end
            OP_LUI: begin
                wr_en  = 1'b1;
                result = {imm, {(NB_DATA-NB_IMM){1'b0}}};
            end
            OP_BEQ:  branch = (rs_val == rt_val);
            default: wr_en  = 1'b0;                          // unsupported, acts as nop
        endcase
    end

    // offset truncates to pc width, same as sign extension mod 64
    assign pc_next = branch ? pc + 1'b1 + iaddr_t'(imm) : pc + 1'b1;

    always_ff @(posedge i_clk) begin
        if (i_rst || dbg.core_rst) begin
            pc <= '0;
            for (int i = 0; i < 2**NB_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (step) begin
            pc <= pc_next;
            if (wr_en && wr_idx != '0) begin                 // r0 stays zero
                regs[wr_idx] <= result;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (dbg.imem_we) begin
            imem[dbg.imem_addr] <= dbg.imem_data;
        end
    end

    a_pc_held: assert property (@(posedge i_clk) disable iff (i_rst || dbg.core_rst)
        dbg.prog_end |=> $stable(pc));

endmodule

`default_nettype wire

//--- verilog/top.sv
`timescale 1ns/1ps
`default_nettype none

module top (
    input  wire clk,
    input  wire i_rst,
    input  wire i_rx,
    output wire o_tx
);
    serial_if   sif ();    // uart <-> debug unit
    core_dbg_if cdbg ();   // debug unit <-> core

    uart uart_inst (
        .i_clk (clk),
        .i_rst (i_rst),
        .i_rx  (i_rx),
        .o_tx  (o_tx),
        .sif   (sif)
    );

    debug_unit debug_unit_inst (
        .i_clk (clk),
        .i_rst (i_rst),
        .sif   (sif),
        .dbg   (cdbg)
    );

    mips_core mips_core_inst (
        .i_clk (clk),
        .i_rst (i_rst),
        .dbg   (cdbg)
    );

endmodule

`default_nettype wire

//--- bench/top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module top_tb import mips_debug_pkg::*; ();
    localparam int BIT_CLKS  = CLKS_PER_TICK * OVERSAMPLING;   // clocks per serial bit
    localparam int NUM_REGS  = 2**NB_REG;
    localparam int DUMP_LEN  = NUM_REGS * BYTES_PER_WORD;

    logic clk;
    logic i_rst;
    logic i_rx;
    wire  o_tx;

    logic [7:0]  op_q[$];         // L, P, E, C or S
    word_t       arg_a_q[$];
    word_t       arg_b_q[$];
    word_t       exp_regs[NUM_REGS];
    word_t       dump_regs[NUM_REGS];
    int          n_bytes;
    int          n_dumps;
    int          dump_no;
    int          error_cnt   = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;  // zero until the tests file is read

    logic [8*160-1:0] line;
    logic [7:0]       tok;
    word_t            arg_a;
    word_t            arg_b;
    logic             loading;
    int               fd;
    int               n;
    int               i;

    top i_dut (
        .clk   (clk),
        .i_rst (i_rst),
        .i_rx  (i_rx),
        .o_tx  (o_tx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        error_cnt++;
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: no dump received");
            abort_run();
        end
    end

    // one uart frame on i_rx, start bit, data lsb first, stop bit
    task automatic send_byte(input byte_t data);
        logic [9:0] frame;
        int         k;
        frame = {1'b1, data, 1'b0};
        for (k = 0; k < 10; k++) begin
            @(posedge clk);
            #1 i_rx = frame[k];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic send_word(input word_t word);
        int k;
        for (k = BYTES_PER_WORD - 1; k >= 0; k--) begin
            send_byte(word[k*NB_BYTE +: NB_BYTE]);     // msb first
        end
    endtask

    // samples o_tx on falling clock edges, at bit centres
    task automatic receive_byte(output byte_t data);
        int k;
        @(negedge clk);
        while (o_tx !== 1'b0) @(negedge clk);
        repeat (BIT_CLKS / 2) @(negedge clk);
        assert (o_tx === 1'b0) else begin
            $display("serial error: start bit from the DUT did not stay low");
            abort_run();
        end
        for (k = 0; k < NB_BYTE; k++) begin
            repeat (BIT_CLKS) @(negedge clk);
            data[k] = o_tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        assert (o_tx === 1'b1) else begin
            $display("serial error: stop bit from the DUT was low");
            abort_run();
        end
    endtask

    task automatic receive_dump();
        byte_t b;
        int    k;
        for (k = 0; k < DUMP_LEN; k++) begin
            receive_byte(b);
            dump_regs[k / BYTES_PER_WORD] = {dump_regs[k / BYTES_PER_WORD][NB_DATA-NB_BYTE-1:0], b};
        end
    endtask

    task automatic check_dump(input int num);
        int r;
        for (r = 0; r < NUM_REGS; r++) begin
            assert (dump_regs[r] === exp_regs[r]) else begin
                $display("FAIL at %0t ns: dump %0d r%0d expected %h got %h",
                         $time, num, r, exp_regs[r], dump_regs[r]);
                abort_run();
            end
            exp_regs[r] = '0;                      // unlisted registers expect zero
        end
        $display("dump %0d matched all %0d registers", num, NUM_REGS);
    endtask

    initial begin
        i_rst   = 1'b1;
        i_rx    = 1'b1;                           // line idles high
        n_bytes = 0;
        n_dumps = 0;
        loading = 1'b0;
        for (i = 0; i < NUM_REGS; i++) begin
            exp_regs[i] = '0;
        end

        fd = $fopen("bench/top_tests.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open bench/top_tests.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", tok);
            if (n == 1 && tok != "#") begin
                case (tok)
                    "P": begin
                        n = $sscanf(line, "%s %h", tok, arg_a);
                        assert (n == 2) else begin
                            $display("tests file: P line without a word");
                            abort_run();
                        end
                        if (!loading) begin              // new program needs an L first
                            op_q.push_back("L");
                            arg_a_q.push_back('0);
                            arg_b_q.push_back('0);
                            n_bytes++;
                            loading = 1'b1;
                        end
                        op_q.push_back("P");
                        arg_a_q.push_back(arg_a);
                        arg_b_q.push_back('0);
                        n_bytes += BYTES_PER_WORD;
                        if (arg_a == HALT_WORD) begin
                            loading = 1'b0;
                        end
                    end
                    "E": begin
                        n = $sscanf(line, "%s %d %h", tok, arg_a, arg_b);
                        assert (n == 3 && arg_a < NUM_REGS) else begin
                            $display("tests file: bad E line");
                            abort_run();
                        end
                        op_q.push_back("E");
                        arg_a_q.push_back(arg_a);
                        arg_b_q.push_back(arg_b);
                    end
                    "C", "S": begin
                        op_q.push_back(tok);
                        arg_a_q.push_back('0);
                        arg_b_q.push_back('0);
                        n_bytes++;
                        n_dumps++;
                    end
                    default: begin
                        $display("tests file: unknown line type %s", tok);
                        abort_run();
                    end
                endcase
            end
        end
        $fclose(fd);
        cycle_limit = (n_bytes + DUMP_LEN * n_dumps) * 10 * BIT_CLKS * 2;

        repeat (8) @(posedge clk);
        #1 i_rst = 1'b0;

        dump_no = 0;
        for (i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "L": send_byte(CMD_LOAD);
                "P": send_word(arg_a_q[i]);
                "E": exp_regs[arg_a_q[i]] = arg_b_q[i];
                default: begin
                    fork                                 // dump may start before stop bit ends
                        send_byte((op_q[i] == "C") ? CMD_RUN : CMD_STEP);
                        receive_dump();
                    join
                    check_dump(dump_no);
                    dump_no++;
                end
            endcase
        end

        if (error_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/top_tests.txt
# P <hex word> loads a word, an L goes before each program; C runs, S steps
# E <reg> <hex> is expected in the next dump; unlisted registers expect 0
P 24010005   addiu r1, r0, 5
P 2402FFFC   addiu r2, r0, -4
P 00221821   addu  r3, r1, r2
P 00222023   subu  r4, r1, r2
P 00222824   and   r5, r1, r2
P 00223025   or    r6, r1, r2
P 0041382A   slt   r7, r2, r1
P 0022402A   slt   r8, r1, r2
P 00210021   addu  r0, r1, r1
P 3C091234   lui   r9, 0x1234
P 3529ABCD   ori   r9, r9, 0xabcd
P 10230001   beq   r1, r3, +1 not taken
P 240A0007   addiu r10, r0, 7
P 11000002   beq   r8, r0, +2 taken
P 240B0001   addiu r11, r0, 1 skipped
P 240C0001   addiu r12, r0, 1 skipped
P 240D0055   addiu r13, r0, 0x55
P FFFFFFFF   halt
E 0 00000000
E 1 00000005
E 2 FFFFFFFC
E 3 00000001
E 4 00000009
E 5 00000004
E 6 FFFFFFFD
E 7 00000001
E 8 00000000
E 9 1234ABCD
E 10 00000007
E 11 00000000
E 12 00000000
E 13 00000055
C
P 24010010   addiu r1, r0, 0x10
P 24220020   addiu r2, r1, 0x20
P 00411823   subu  r3, r2, r1
P FFFFFFFF   halt
E 1 00000010
S
E 1 00000010
E 2 00000030
S
E 1 00000010
E 2 00000030
E 3 00000020
S
P 340400F0   ori   r4, r0, 0xf0
P FFFFFFFF   halt
E 4 000000F0
C

//--- top.f
verilog/mips_debug_pkg.sv
verilog/mips_debug_ifs.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart.sv
verilog/debug_unit.sv
verilog/mips_core.sv
verilog/top.sv
bench/top_tb.sv
